//--- all.f
gpio_pkg.sv
reset_sync.sv
gpio_pad_sync.sv
gpio_regs.sv
gpio.sv
gpio_assertions.sv
tb_gpio.sv

//--- run.sh
#!/bin/sh
# build and run the gpio testbench with Verilator.
verilator --binary --timing --assert --top-module tb_gpio -f all.f -o sim_gpio \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_gpio +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- tb_gpio.sv
`default_nettype none

module tb_gpio;

	timeunit 1ns;
	timeprecision 100ps;

	import gpio_pkg::*;

	localparam int MAX_CYCLES   = 4000;
	localparam int RESET_CYCLES = 16;

	logic      clk;
	logic      rst_n_i;
	logic      apb_psel;
	logic      apb_penable;
	logic      apb_pwrite;
	apb_addr_t apb_paddr;
	apb_data_t apb_pwdata;
	apb_data_t apb_prdata;
	logic      apb_pready;
	logic      apb_pslverr;
	pad_vec_t  pad_out;
	pad_vec_t  pad_oe;
	pad_vec_t  pad_in;
	logic      irq;

	logic [31:0] lfsr_q;
	int          check_errors;
	int          cycle_count;

	// register model.
	logic     m_out;
	logic     m_dir;
	pad_vec_t m_press;
	pad_vec_t m_en;

	gpio dut_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.apb_psel_i    (apb_psel),
		.apb_penable_i (apb_penable),
		.apb_pwrite_i  (apb_pwrite),
		.apb_paddr_i   (apb_paddr),
		.apb_pwdata_i  (apb_pwdata),
		.apb_prdata_o  (apb_prdata),
		.apb_pready_o  (apb_pready),
		.apb_pslverr_o (apb_pslverr),
		.pad_out_o     (pad_out),
		.pad_oe_o      (pad_oe),
		.pad_in_i      (pad_in),
		.irq_o         (irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			value  = {value[30:0], lfsr_q[0]};
		end
	endtask

	// one setup cycle, then the access cycle.
	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		@(negedge clk);
		apb_psel    = 1'b1;
		apb_penable = 1'b0;
		apb_pwrite  = write;
		apb_paddr   = addr;
		apb_pwdata  = wdata;
		@(negedge clk);
		apb_penable = 1'b1;
		#1;
		while (!apb_pready) begin
			@(negedge clk);
			#1;
		end
		rdata = apb_prdata;
		err   = apb_pslverr;
		@(negedge clk);
		apb_psel    = 1'b0;
		apb_penable = 1'b0;
		apb_pwrite  = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t wdata, input string name);
		apb_data_t rdata;
		logic      err;
		apb_access(1'b1, addr, wdata, rdata, err);
		if (err) begin
			check_errors++;
			$display("FAILED at %0t: write to %s returned pslverr", $time, name);
		end
	endtask

	task automatic check_reg(input apb_addr_t addr, input apb_data_t expected, input string name);
		apb_data_t rdata;
		logic      err;
		apb_access(1'b0, addr, '0, rdata, err);
		if (err || rdata !== expected) begin
			check_errors++;
			$display("FAILED at %0t: %s read %h with pslverr %b, expected %h",
				$time, name, rdata, err, expected);
		end
	endtask

	task automatic check_bad_access(input logic write, input apb_addr_t addr,
			input apb_data_t wdata);
		apb_data_t rdata;
		logic      err;
		apb_access(write, addr, wdata, rdata, err);
		if (!err || rdata !== '0) begin
			check_errors++;
			$display("FAILED at %0t: bad access at %h (write %b) gave pslverr %b, data %h",
				$time, addr, write, err, rdata);
		end
	endtask

	task automatic check_all_regs();
		check_reg(REG_OUT, apb_data_t'(m_out), "OUT");
		check_reg(REG_DIR, apb_data_t'(m_dir), "DIR");
		check_reg(REG_IN, apb_data_t'(pad_in), "IN");
		check_reg(REG_PRESS, apb_data_t'(m_press), "PRESS");
		check_reg(REG_IRQ_EN, apb_data_t'(m_en), "IRQ_EN");
	endtask

	task automatic check_pins();
		pad_vec_t exp_out;
		pad_vec_t exp_oe;
		logic     exp_irq;
		exp_out = '0;
		exp_oe  = '0;
		exp_out[PIN_LED] = m_out;
		exp_oe[PIN_LED]  = m_dir;
		exp_irq = |(m_press & m_en);
		if (pad_out !== exp_out || pad_oe !== exp_oe) begin
			check_errors++;
			$display("FAILED at %0t: pads out %h oe %h, expected out %h oe %h",
				$time, pad_out, pad_oe, exp_out, exp_oe);
		end
		if (irq !== exp_irq) begin
			check_errors++;
			$display("FAILED at %0t: irq_o is %b, expected %b", $time, irq, exp_irq);
		end
	endtask

	// held long enough for the press flag to land.
	task automatic set_pads(input pad_vec_t value);
		@(negedge clk);
		m_press = m_press | (value & ~pad_in);
		pad_in  = value;
		repeat (5) @(negedge clk);
	endtask

	task automatic clear_press(input apb_data_t mask);
		write_reg(REG_PRESS, mask, "PRESS");
		m_press = m_press & ~mask[N_PADS-1:0];
	endtask

	initial begin
		logic [31:0] rnd;
		apb_addr_t   bad_addr;
		int          assert_errors;

		lfsr_q       = 32'he3c8;
		check_errors = 0;
		cycle_count  = 0;
		m_out        = 1'b0;
		m_dir        = 1'b0;
		m_press      = '0;
		m_en         = '0;
		rst_n_i      = 1'b0;
		apb_psel     = 1'b0;
		apb_penable  = 1'b0;
		apb_pwrite   = 1'b0;
		apb_paddr    = '0;
		apb_pwdata   = '0;
		pad_in       = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n_i = 1'b1;
		repeat (4) @(negedge clk);

		check_all_regs();
		check_pins();

		// led control.
		repeat (8) begin
			draw_bits(32, rnd);
			write_reg(REG_OUT, rnd, "OUT");
			m_out = rnd[0];
			draw_bits(32, rnd);
			write_reg(REG_DIR, rnd, "DIR");
			m_dir = rnd[0];
			check_pins();
			check_reg(REG_OUT, apb_data_t'(m_out), "OUT");
			check_reg(REG_DIR, apb_data_t'(m_dir), "DIR");
		end

		// input readback.
		repeat (6) begin
			draw_bits(N_PADS, rnd);
			set_pads(rnd[N_PADS-1:0]);
			check_reg(REG_IN, apb_data_t'(pad_in), "IN");
		end
		check_reg(REG_PRESS, apb_data_t'(m_press), "PRESS");

		// press flags, partial clears, falling pads.
		repeat (5) begin
			set_pads('0);
			clear_press(32'hffff_ffff);
			check_reg(REG_PRESS, '0, "PRESS");
			draw_bits(N_PADS, rnd);
			set_pads(rnd[N_PADS-1:0]);
			check_reg(REG_PRESS, apb_data_t'(m_press), "PRESS");
			draw_bits(32, rnd);
			clear_press(rnd);
			check_reg(REG_PRESS, apb_data_t'(m_press), "PRESS");
			set_pads('0);
			check_reg(REG_PRESS, apb_data_t'(m_press), "PRESS");
		end

		// interrupt against random enables.
		repeat (6) begin
			draw_bits(N_PADS, rnd);
			write_reg(REG_IRQ_EN, rnd, "IRQ_EN");
			m_en = rnd[N_PADS-1:0];
			check_pins();
			draw_bits(N_PADS, rnd);
			set_pads(rnd[N_PADS-1:0]);
			check_pins();
			check_reg(REG_PRESS, apb_data_t'(m_press), "PRESS");
			draw_bits(N_PADS, rnd);
			clear_press(rnd);
			check_pins();
			check_reg(REG_IRQ_EN, apb_data_t'(m_en), "IRQ_EN");
		end

		// error responses.
		check_bad_access(1'b0, 16'h0014, '0);
		check_bad_access(1'b0, 16'h0002, '0);
		check_bad_access(1'b1, 16'h0100, 32'hffff_ffff);
		check_bad_access(1'b1, REG_IN, 32'h0000_07ff);
		repeat (4) begin
			draw_bits(16, rnd);
			// bit 5 set puts it above the last mapped offset.
			bad_addr = rnd[15:0] | 16'h0020;
			draw_bits(32, rnd);
			check_bad_access(1'b1, bad_addr, rnd);
			check_bad_access(1'b0, bad_addr, '0);
		end
		check_all_regs();
		check_pins();

		repeat (2) @(negedge clk);
		assert_errors = dut_i.u_assert.fail_count;
		$display("done: %0d readback errors, %0d assertion errors", check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- gpio_assertions.sv
`default_nettype none

module gpio_assertions (
	input wire logic                clk,
	input wire logic                rst_n_sync,
	input wire logic                apb_psel_i,
	input wire logic                apb_penable_i,
	input wire logic                apb_pwrite_i,
	input wire gpio_pkg::apb_addr_t apb_paddr_i,
	input wire gpio_pkg::apb_data_t apb_pwdata_i,
	input wire gpio_pkg::apb_data_t apb_prdata_o,
	input wire logic                apb_pready_o,
	input wire logic                apb_pslverr_o,
	input wire gpio_pkg::pad_vec_t  pad_out_o,
	input wire gpio_pkg::pad_vec_t  pad_oe_o,
	input wire logic                irq_o
);

	timeunit 1ns;
	timeprecision 100ps;

	import gpio_pkg::*;

	localparam pad_vec_t LED_MASK = pad_vec_t'(1) << PIN_LED;

	int fail_count;

	logic     wr_commit;
	logic     rd_press;
	logic     mirror_out;
	logic     mirror_dir;
	pad_vec_t mirror_en;

	initial fail_count = 0;

	assign wr_commit = apb_psel_i && apb_penable_i && apb_pwrite_i;
	assign rd_press  = apb_psel_i && apb_penable_i && !apb_pwrite_i &&
		(apb_paddr_i == REG_PRESS);

	// shadow of the writable registers as seen from the bus.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			mirror_out <= 1'b0;
			mirror_dir <= 1'b0;
			mirror_en  <= '0;
		end else if (wr_commit) begin
			if (apb_paddr_i == REG_OUT) begin
				mirror_out <= apb_pwdata_i[0];
			end
			if (apb_paddr_i == REG_DIR) begin
				mirror_dir <= apb_pwdata_i[0];
			end
			if (apb_paddr_i == REG_IRQ_EN) begin
				mirror_en <= apb_pwdata_i[N_PADS-1:0];
			end
		end
	end

	a_pready: assert property (@(posedge clk) disable iff (!rst_n_sync) apb_pready_o)
		else begin
			fail_count = fail_count + 1;
			$error("pready went low after reset");
		end

	a_unused_pads: assert property (@(posedge clk) disable iff (!rst_n_sync)
		((pad_out_o | pad_oe_o) & ~LED_MASK) == '0)
		else begin
			fail_count = fail_count + 1;
			$error("a pad other than the led is driven");
		end

	a_led: assert property (@(posedge clk) disable iff (!rst_n_sync)
		(pad_out_o[PIN_LED] == mirror_out) && (pad_oe_o[PIN_LED] == mirror_dir))
		else begin
			fail_count = fail_count + 1;
			$error("led pin does not follow the written registers");
		end

	// flags come straight off the read data.
	a_irq: assert property (@(posedge clk) disable iff (!rst_n_sync)
		rd_press |-> (irq_o == |(apb_prdata_o[N_PADS-1:0] & mirror_en)))
		else begin
			fail_count = fail_count + 1;
			$error("irq does not match pressed and enabled flags");
		end

	// an access cycle is the one right after a setup cycle.
	a_err_phase: assert property (@(posedge clk) disable iff (!rst_n_sync)
		apb_pslverr_o |-> (apb_psel_i && apb_penable_i &&
			$past(apb_psel_i && !apb_penable_i)))
		else begin
			fail_count = fail_count + 1;
			$error("pslverr high outside an access cycle");
		end

	a_err_rdata: assert property (@(posedge clk) disable iff (!rst_n_sync)
		(apb_pslverr_o && !apb_pwrite_i) |-> (apb_prdata_o == '0))
		else begin
			fail_count = fail_count + 1;
			$error("erroring read returned nonzero data");
		end

endmodule

bind gpio gpio_assertions u_assert (.*);

`default_nettype wire

//--- gpio.sv
`default_nettype none

module gpio (
	input  wire logic               clk,
	input  wire logic               rst_n_i,

	input  wire logic               apb_psel_i,
	input  wire logic               apb_penable_i,
	input  wire logic               apb_pwrite_i,
	input  wire gpio_pkg::apb_addr_t apb_paddr_i,
	input  wire gpio_pkg::apb_data_t apb_pwdata_i,
	output gpio_pkg::apb_data_t     apb_prdata_o,
	output logic                    apb_pready_o,
	output logic                    apb_pslverr_o,

	output gpio_pkg::pad_vec_t      pad_out_o,
	output gpio_pkg::pad_vec_t      pad_oe_o,
	input  wire gpio_pkg::pad_vec_t  pad_in_i,

	output logic                    irq_o
);

	import gpio_pkg::*;

	logic     rst_n_sync;
	pad_vec_t in_level;
	pad_vec_t in_rise;
	logic     led_out;
	logic     led_oe;

	reset_sync #(
		.N_CYCLES (RESET_SYNC_STAGES)
	) u_reset_sync (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.rst_n_sync_o (rst_n_sync)
	);

	gpio_pad_sync u_pad_sync (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.pad_in_i   (pad_in_i),
		.in_level_o (in_level),
		.in_rise_o  (in_rise)
	);

	gpio_regs u_regs (
		.clk           (clk),
		.rst_n_sync    (rst_n_sync),
		.apb_psel_i    (apb_psel_i),
		.apb_penable_i (apb_penable_i),
		.apb_pwrite_i  (apb_pwrite_i),
		.apb_paddr_i   (apb_paddr_i),
		.apb_pwdata_i  (apb_pwdata_i),
		.apb_prdata_o  (apb_prdata_o),
		.apb_pready_o  (apb_pready_o),
		.apb_pslverr_o (apb_pslverr_o),
		.in_level_i    (in_level),
		.in_rise_i     (in_rise),
		.led_out_o     (led_out),
		.led_oe_o      (led_oe),
		.irq_o         (irq_o)
	);

	// only the led pin is an output, the rest stay tied low.
	genvar pin;
	for (pin = 0; pin < N_PADS; pin++) begin : g_pad
		if (pin == PIN_LED) begin : g_led
			assign pad_out_o[pin] = led_out;
			assign pad_oe_o[pin]  = led_oe;
		end else begin : g_unused
			assign pad_out_o[pin] = 1'b0;
			assign pad_oe_o[pin]  = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- gpio_regs.sv
`default_nettype none

module gpio_regs (
	input  wire logic               clk,
	input  wire logic               rst_n_sync,

	input  wire logic               apb_psel_i,
	input  wire logic               apb_penable_i,
	input  wire logic               apb_pwrite_i,
	input  wire gpio_pkg::apb_addr_t apb_paddr_i,
	input  wire gpio_pkg::apb_data_t apb_pwdata_i,
	output gpio_pkg::apb_data_t     apb_prdata_o,
	output logic                    apb_pready_o,
	output logic                    apb_pslverr_o,

	input  wire gpio_pkg::pad_vec_t  in_level_i,
	input  wire gpio_pkg::pad_vec_t  in_rise_i,

	output logic                    led_out_o,
	output logic                    led_oe_o,
	output logic                    irq_o
);

	import gpio_pkg::*;

	reg_state_t state_q;
	reg_state_t state_d;

	logic access;
	logic hit_out;
	logic hit_dir;
	logic hit_in;
	logic hit_press;
	logic hit_irq_en;
	logic addr_err;
	logic wr_ok;
	logic rd_ok;

	logic     out_q;
	logic     dir_q;
	pad_vec_t press_q;
	pad_vec_t irq_en_q;
	pad_vec_t press_clr;

	apb_data_t rdata;

	// a genuine access cycle must follow a setup cycle.
	assign access = apb_psel_i && apb_penable_i && (state_q == SETUP);

	always_comb begin
		state_d = IDLE;
		if (apb_psel_i && !apb_penable_i) begin
			state_d = SETUP;
		end else if (access) begin
			state_d = ACCESS;
		end
	end

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// address decode.
	assign hit_out    = (apb_paddr_i == REG_OUT);
	assign hit_dir    = (apb_paddr_i == REG_DIR);
	assign hit_in     = (apb_paddr_i == REG_IN);
	assign hit_press  = (apb_paddr_i == REG_PRESS);
	assign hit_irq_en = (apb_paddr_i == REG_IRQ_EN);

	assign addr_err = !(hit_out || hit_dir || hit_in || hit_press || hit_irq_en);

	// unmapped offset, or a write to the read-only input register.
	assign apb_pslverr_o = access && (addr_err || (apb_pwrite_i && hit_in));

	assign wr_ok = access && apb_pwrite_i && !apb_pslverr_o;
	assign rd_ok = access && !apb_pwrite_i && !addr_err;

	// no wait states.
	assign apb_pready_o = 1'b1;

	// led control.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			out_q <= 1'b0;
			dir_q <= 1'b0;
		end else begin
			if (wr_ok && hit_out) begin
				out_q <= apb_pwdata_i[0];
			end
			if (wr_ok && hit_dir) begin
				dir_q <= apb_pwdata_i[0];
			end
		end
	end

	// interrupt enables.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			irq_en_q <= '0;
		end else if (wr_ok && hit_irq_en) begin
			irq_en_q <= apb_pwdata_i[N_PADS-1:0];
		end
	end

	// write one to clear.
	assign press_clr = (wr_ok && hit_press) ? apb_pwdata_i[N_PADS-1:0] : '0;

	// a new rise wins over a clear in the same cycle.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			press_q <= '0;
		end else begin
			press_q <= (press_q & ~press_clr) | in_rise_i;
		end
	end

	// read data is zero on error or outside an access.
	always_comb begin
		rdata = '0;
		if (rd_ok) begin
			case (apb_paddr_i)
				REG_OUT:    rdata = apb_data_t'(out_q);
				REG_DIR:    rdata = apb_data_t'(dir_q);
				REG_IN:     rdata = apb_data_t'(in_level_i);
				REG_PRESS:  rdata = apb_data_t'(press_q);
				REG_IRQ_EN: rdata = apb_data_t'(irq_en_q);
				default:    rdata = '0;
			endcase
		end
	end

	assign apb_prdata_o = rdata;

	assign led_out_o = out_q;
	assign led_oe_o  = dir_q;

	// level interrupt.
	assign irq_o = |(press_q & irq_en_q);

endmodule

`default_nettype wire

//--- gpio_pad_sync.sv
`default_nettype none

module gpio_pad_sync (
	input  wire logic              clk,
	input  wire logic              rst_n_sync,
	input  wire gpio_pkg::pad_vec_t pad_in_i,
	output gpio_pkg::pad_vec_t     in_level_o,
	output gpio_pkg::pad_vec_t     in_rise_o
);

	import gpio_pkg::*;

	pad_vec_t meta_q;
	pad_vec_t sync_q;
	pad_vec_t prev_q;

	// two-flop synchronizer for the asynchronous pads.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			meta_q <= '0;
			sync_q <= '0;
		end else begin
			meta_q <= pad_in_i;
			sync_q <= meta_q;
		end
	end

	// previous level for edge detection.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			prev_q <= '0;
		end else begin
			prev_q <= sync_q;
		end
	end

	assign in_level_o = sync_q;

	// zero last cycle, one now.
	// a pad held high through reset gives one pulse after release.
	assign in_rise_o = sync_q & ~prev_q;

endmodule

`default_nettype wire

//--- reset_sync.sv
`default_nettype none

module reset_sync #(
	parameter int N_CYCLES = gpio_pkg::RESET_SYNC_STAGES
) (
	input  wire logic clk,
	input  wire logic rst_n_i,
	output logic      rst_n_sync_o
);

	logic [N_CYCLES-1:0] chain_q;

	// clears at once, fills with ones after release.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			chain_q <= '0;
		end else begin
			chain_q <= {chain_q[N_CYCLES-2:0], 1'b1};
		end
	end

	// last stage is the released reset.
	assign rst_n_sync_o = chain_q[N_CYCLES-1];

endmodule

`default_nettype wire

//--- gpio_pkg.sv
`default_nettype none

package gpio_pkg;

	// pad count.
	localparam int N_PADS = 11;

	// pin map, one index per pad.
	localparam int PIN_LED        = 0;
	localparam int PIN_DPAD_U     = 1;
	localparam int PIN_DPAD_D     = 2;
	localparam int PIN_DPAD_L     = 3;
	localparam int PIN_DPAD_R     = 4;
	localparam int PIN_BTN_A      = 5;
	localparam int PIN_BTN_B      = 6;
	localparam int PIN_BTN_X      = 7;
	localparam int PIN_BTN_Y      = 8;
	localparam int PIN_BTN_START  = 9;
	localparam int PIN_BTN_SELECT = 10;

	// depth of the reset release chain.
	localparam int RESET_SYNC_STAGES = 2;

	// bus widths.
	localparam int APB_ADDR_W = 16;
	localparam int APB_DATA_W = 32;

	// one bit per pad, indexed by pin.
	typedef logic [N_PADS-1:0] pad_vec_t;

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// register byte offsets.
	localparam apb_addr_t REG_OUT    = 16'h0000;
	localparam apb_addr_t REG_DIR    = 16'h0004;
	localparam apb_addr_t REG_IN     = 16'h0008;
	localparam apb_addr_t REG_PRESS  = 16'h000C;
	localparam apb_addr_t REG_IRQ_EN = 16'h0010;

	// phase of the previous bus cycle as seen by the slave.
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} reg_state_t;

endpackage

`default_nettype wire
